// File: hdl/mem_bus_consts.svh
/*
 * shared sizes of the scratch memory bus
 * widths, port count, pending limit and queue depths
 */
`ifndef MEM_BUS_CONSTS_SVH
`define MEM_BUS_CONSTS_SVH

// bus field widths
`define MB_ADDR_W       8   // word address, 256 words
`define MB_DATA_W       32  // data word

// requester side
`define MB_NUM_PORTS    2   // peer requester ports
`define MB_NUM_PENDING  2   // open transactions per port by default

// queue depths
`define MB_ROUTE_DEPTH  4   // arbiter return-path queue
`define MB_RSP_DEPTH    2   // sram response queue

`endif

// File: hdl/mem_bus_pkg.sv
/*
 * types of the single-beat scratch memory bus
 * opcode and isolation state enums, field vectors, port index
 */
`include "mem_bus_consts.svh"

package mem_bus_pkg;

  // request opcode, echoed on the response
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mb_op_e;

  // isolation fsm of one port
  typedef enum logic [1:0] {
    ISO_NORMAL,   // straight connection
    ISO_HOLD,     // request valid held until accepted
    ISO_DRAIN,    // no new requests, open responses drain
    ISO_ISOLATE   // port fully cut
  } iso_state_e;

  typedef logic [`MB_ADDR_W-1:0]             mb_addr_t;
  typedef logic [`MB_DATA_W-1:0]             mb_data_t;
  typedef logic [$clog2(`MB_NUM_PORTS)-1:0]  mb_port_t;  // requester index

endpackage

// File: hdl/bus_isolate.sv
/*
 * bus isolation for one requester port
 * counts open transactions, drains them on isolate_i, then cuts the port
 */
`include "mem_bus_consts.svh"

module bus_isolate #(
  parameter int unsigned NUM_PENDING = `MB_NUM_PENDING  // open transaction limit, 1 or more
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // upstream, from the requester
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  mem_bus_pkg::mb_op_e   req_op_i,
  input  mem_bus_pkg::mb_addr_t req_addr_i,
  input  mem_bus_pkg::mb_data_t req_wdata_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output mem_bus_pkg::mb_op_e   rsp_op_o,
  output mem_bus_pkg::mb_data_t rsp_rdata_o,
  // downstream, toward the arbiter
  output logic                  mreq_valid_o,
  input  logic                  mreq_ready_i,
  output mem_bus_pkg::mb_op_e   mreq_op_o,
  output mem_bus_pkg::mb_addr_t mreq_addr_o,
  output mem_bus_pkg::mb_data_t mreq_wdata_o,
  input  logic                  mrsp_valid_i,
  output logic                  mrsp_ready_o,
  input  mem_bus_pkg::mb_op_e   mrsp_op_i,
  input  mem_bus_pkg::mb_data_t mrsp_rdata_i,
  // isolation control
  input  logic                  isolate_i,
  output logic                  isolated_o
);
  import mem_bus_pkg::*;

  // one extra code for zero open transactions
  localparam int unsigned CNT_W = $clog2(NUM_PENDING + 1);

  iso_state_e       state_q, state_d;
  logic [CNT_W-1:0] pending_q, pending_d;
  logic             req_xfer;  // request leaves downstream
  logic             rsp_xfer;  // response taken upstream
  logic             at_limit;

  assign req_xfer = mreq_valid_o & mreq_ready_i;
  assign rsp_xfer = rsp_valid_o & rsp_ready_i;
  assign at_limit = (pending_q == CNT_W'(NUM_PENDING));

  //////////////////////////////////////////////////////////////////////
  // open transaction counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pending_d = pending_q;
    unique case ({req_xfer, rsp_xfer})
      2'b10:   pending_d = pending_q + CNT_W'(1);
      2'b01:   pending_d = pending_q - CNT_W'(1);
      default: pending_d = pending_q;  // none, or one in and one out
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // isolation fsm and channel gating
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    // straight through by default
    mreq_valid_o = req_valid_i;
    req_ready_o  = mreq_ready_i;
    mreq_op_o    = req_op_i;
    mreq_addr_o  = req_addr_i;
    mreq_wdata_o = req_wdata_i;
    rsp_valid_o  = mrsp_valid_i;
    mrsp_ready_o = rsp_ready_i;
    rsp_op_o     = mrsp_op_i;
    rsp_rdata_o  = mrsp_rdata_i;

    unique case (state_q)
      ISO_NORMAL: begin
        if (at_limit) begin
          // limit reached, stall the handshake
          mreq_valid_o = 1'b0;
          req_ready_o  = 1'b0;
          if (isolate_i) begin
            state_d = ISO_DRAIN;
          end
        end else if (req_valid_i && !mreq_ready_i) begin
          state_d = ISO_HOLD;  // offered but not taken yet
        end else if (isolate_i) begin
          state_d = ISO_DRAIN;
        end
      end
      ISO_HOLD: begin
        mreq_valid_o = 1'b1;  // keep the offer up, ready passes
        if (mreq_ready_i) begin
          state_d = isolate_i ? ISO_DRAIN : ISO_NORMAL;
        end
      end
      ISO_DRAIN: begin
        mreq_valid_o = 1'b0;
        req_ready_o  = 1'b0;
        mreq_op_o    = OP_READ;
        mreq_addr_o  = '0;
        mreq_wdata_o = '0;
        // responses still flow until the count is empty
        if (pending_q == '0) begin
          state_d = ISO_ISOLATE;
        end
      end
      ISO_ISOLATE: begin
        mreq_valid_o = 1'b0;
        req_ready_o  = 1'b0;
        mreq_op_o    = OP_READ;
        mreq_addr_o  = '0;
        mreq_wdata_o = '0;
        rsp_valid_o  = 1'b0;  // response side cut too
        mrsp_ready_o = 1'b0;
        rsp_op_o     = OP_READ;
        rsp_rdata_o  = '0;
        if (!isolate_i) begin
          state_d = ISO_NORMAL;
        end
      end
      default: state_d = ISO_ISOLATE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ISO_ISOLATE;  // port comes up cut
      pending_q <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

  assign isolated_o = (state_q == ISO_ISOLATE);  // decoded from the register

endmodule

// File: hdl/rr_bus_arbiter.sv
/*
 * round-robin arbiter merging the requester slots onto one memory bus
 * an in-order route queue sends each response back to its slot
 */
`include "mem_bus_consts.svh"

module rr_bus_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  // requester slots
  input  logic                  [`MB_NUM_PORTS-1:0] s_req_valid_i,
  output logic                  [`MB_NUM_PORTS-1:0] s_req_ready_o,
  input  mem_bus_pkg::mb_op_e   [`MB_NUM_PORTS-1:0] s_req_op_i,
  input  mem_bus_pkg::mb_addr_t [`MB_NUM_PORTS-1:0] s_req_addr_i,
  input  mem_bus_pkg::mb_data_t [`MB_NUM_PORTS-1:0] s_req_wdata_i,
  output logic                  [`MB_NUM_PORTS-1:0] s_rsp_valid_o,
  input  logic                  [`MB_NUM_PORTS-1:0] s_rsp_ready_i,
  output mem_bus_pkg::mb_op_e   [`MB_NUM_PORTS-1:0] s_rsp_op_o,
  output mem_bus_pkg::mb_data_t [`MB_NUM_PORTS-1:0] s_rsp_rdata_o,
  // toward the memory
  output logic                                     m_req_valid_o,
  input  logic                                     m_req_ready_i,
  output mem_bus_pkg::mb_op_e                      m_req_op_o,
  output mem_bus_pkg::mb_addr_t                    m_req_addr_o,
  output mem_bus_pkg::mb_data_t                    m_req_wdata_o,
  input  logic                                     m_rsp_valid_i,
  output logic                                     m_rsp_ready_o,
  input  mem_bus_pkg::mb_op_e                      m_rsp_op_i,
  input  mem_bus_pkg::mb_data_t                    m_rsp_rdata_i
);
  import mem_bus_pkg::*;

  localparam int unsigned NP    = `MB_NUM_PORTS;
  localparam int unsigned RD    = `MB_ROUTE_DEPTH;
  localparam int unsigned PTR_W = (RD > 1) ? $clog2(RD) : 1;
  localparam int unsigned CNT_W = $clog2(RD + 1);

  mb_port_t         prio_q;        // slot with top priority
  mb_port_t         grant_idx;
  mb_port_t         head_idx;      // owner of the oldest open response
  logic             any_valid;
  logic             route_full, route_empty, push, pop;
  mb_port_t         route_mem [RD];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(RD - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // walk down so the slot nearest prio_q wins
  always_comb begin
    grant_idx = prio_q;
    any_valid = 1'b0;
    for (int i = NP - 1; i >= 0; i--) begin
      if (s_req_valid_i[(int'(prio_q) + i) % NP]) begin
        grant_idx = mb_port_t'((int'(prio_q) + i) % NP);
        any_valid = 1'b1;
      end
    end
  end

  assign route_full    = (count_q == CNT_W'(RD));
  assign route_empty   = (count_q == '0);
  assign m_req_valid_o = any_valid & ~route_full;  // stall on a full route
  assign m_req_op_o    = s_req_op_i[grant_idx];
  assign m_req_addr_o  = s_req_addr_i[grant_idx];
  assign m_req_wdata_o = s_req_wdata_i[grant_idx];
  assign push          = m_req_valid_o & m_req_ready_i;

  always_comb begin
    s_req_ready_o            = '0;
    s_req_ready_o[grant_idx] = m_req_ready_i & ~route_full;
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  assign head_idx      = route_mem[rd_ptr_q];
  assign m_rsp_ready_o = s_rsp_ready_i[head_idx] & ~route_empty;
  assign pop           = m_rsp_valid_i & m_rsp_ready_o;

  always_comb begin
    s_rsp_valid_o           = '0;
    s_rsp_valid_o[head_idx] = m_rsp_valid_i & ~route_empty;
    for (int i = 0; i < NP; i++) begin
      s_rsp_op_o[i]    = m_rsp_op_i;     // payload fans out, valid selects
      s_rsp_rdata_o[i] = m_rsp_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      route_mem[wr_ptr_q] <= grant_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // a waiting grant keeps its slot, a taken one rotates past it
      if (m_req_valid_o) begin
        prio_q <= m_req_ready_i ? mb_port_t'((int'(grant_idx) + 1) % NP) : grant_idx;
      end
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hdl/bus_sram.sv
/*
 * synchronous scratch sram slave
 * writes land at acceptance, responses wait in a small queue
 */
`include "mem_bus_consts.svh"

module bus_sram (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  mem_bus_pkg::mb_op_e   req_op_i,
  input  mem_bus_pkg::mb_addr_t req_addr_i,
  input  mem_bus_pkg::mb_data_t req_wdata_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output mem_bus_pkg::mb_op_e   rsp_op_o,
  output mem_bus_pkg::mb_data_t rsp_rdata_o
);
  import mem_bus_pkg::*;

  localparam int unsigned DEPTH = `MB_RSP_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mb_data_t         mem [2**`MB_ADDR_W];  // word array
  mb_op_e           rsp_op_mem   [DEPTH];
  mb_data_t         rsp_data_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, empty, accept, pop;

  assign full        = (count_q == CNT_W'(DEPTH));
  assign empty       = (count_q == '0);
  assign pop         = rsp_valid_o & rsp_ready_i;
  assign req_ready_o = ~full | pop;  // a leaving entry frees its slot
  assign accept      = req_valid_i & req_ready_o;
  assign rsp_valid_o = ~empty;
  assign rsp_op_o    = rsp_op_mem[rd_ptr_q];
  assign rsp_rdata_o = rsp_data_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_op_mem[wr_ptr_q] <= req_op_i;
      if (req_op_i == OP_WRITE) begin
        mem[req_addr_i]        <= req_wdata_i;
        rsp_data_mem[wr_ptr_q] <= '0;  // write ack carries no data
      end else begin
        rsp_data_mem[wr_ptr_q] <= mem[req_addr_i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (accept) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      if (pop)    rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      unique case ({accept, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hdl/isolated_mem_top.sv
/*
 * shared scratch memory with two isolated requester ports
 * isolators feed a round-robin arbiter in front of one sram
 */
`include "mem_bus_consts.svh"

module isolated_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // port 0
  input  logic                  req_valid_0_i,
  output logic                  req_ready_0_o,
  input  mem_bus_pkg::mb_op_e   req_op_0_i,
  input  mem_bus_pkg::mb_addr_t req_addr_0_i,
  input  mem_bus_pkg::mb_data_t req_wdata_0_i,
  output logic                  rsp_valid_0_o,
  input  logic                  rsp_ready_0_i,
  output mem_bus_pkg::mb_op_e   rsp_op_0_o,
  output mem_bus_pkg::mb_data_t rsp_rdata_0_o,
  input  logic                  isolate_0_i,
  output logic                  isolated_0_o,
  // port 1
  input  logic                  req_valid_1_i,
  output logic                  req_ready_1_o,
  input  mem_bus_pkg::mb_op_e   req_op_1_i,
  input  mem_bus_pkg::mb_addr_t req_addr_1_i,
  input  mem_bus_pkg::mb_data_t req_wdata_1_i,
  output logic                  rsp_valid_1_o,
  input  logic                  rsp_ready_1_i,
  output mem_bus_pkg::mb_op_e   rsp_op_1_o,
  output mem_bus_pkg::mb_data_t rsp_rdata_1_o,
  input  logic                  isolate_1_i,
  output logic                  isolated_1_o
);
  import mem_bus_pkg::*;

  localparam mb_port_t PORT_0 = mb_port_t'(0);
  localparam mb_port_t PORT_1 = mb_port_t'(1);

  // isolator to arbiter slots
  logic     [`MB_NUM_PORTS-1:0] s_req_valid, s_req_ready, s_rsp_valid, s_rsp_ready;
  mb_op_e   [`MB_NUM_PORTS-1:0] s_req_op, s_rsp_op;
  mb_addr_t [`MB_NUM_PORTS-1:0] s_req_addr;
  mb_data_t [`MB_NUM_PORTS-1:0] s_req_wdata, s_rsp_rdata;

  // arbiter to sram
  logic     m_req_valid, m_req_ready, m_rsp_valid, m_rsp_ready;
  mb_op_e   m_req_op, m_rsp_op;
  mb_addr_t m_req_addr;
  mb_data_t m_req_wdata, m_rsp_rdata;

  //////////////////////////////////////////////////////////////////////
  // per-port isolation
  //////////////////////////////////////////////////////////////////////

  bus_isolate i_iso_0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_0_i),
    .req_ready_o  (req_ready_0_o),
    .req_op_i     (req_op_0_i),
    .req_addr_i   (req_addr_0_i),
    .req_wdata_i  (req_wdata_0_i),
    .rsp_valid_o  (rsp_valid_0_o),
    .rsp_ready_i  (rsp_ready_0_i),
    .rsp_op_o     (rsp_op_0_o),
    .rsp_rdata_o  (rsp_rdata_0_o),
    .mreq_valid_o (s_req_valid[PORT_0]),
    .mreq_ready_i (s_req_ready[PORT_0]),
    .mreq_op_o    (s_req_op[PORT_0]),
    .mreq_addr_o  (s_req_addr[PORT_0]),
    .mreq_wdata_o (s_req_wdata[PORT_0]),
    .mrsp_valid_i (s_rsp_valid[PORT_0]),
    .mrsp_ready_o (s_rsp_ready[PORT_0]),
    .mrsp_op_i    (s_rsp_op[PORT_0]),
    .mrsp_rdata_i (s_rsp_rdata[PORT_0]),
    .isolate_i    (isolate_0_i),
    .isolated_o   (isolated_0_o)
  );

  bus_isolate i_iso_1 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_1_i),
    .req_ready_o  (req_ready_1_o),
    .req_op_i     (req_op_1_i),
    .req_addr_i   (req_addr_1_i),
    .req_wdata_i  (req_wdata_1_i),
    .rsp_valid_o  (rsp_valid_1_o),
    .rsp_ready_i  (rsp_ready_1_i),
    .rsp_op_o     (rsp_op_1_o),
    .rsp_rdata_o  (rsp_rdata_1_o),
    .mreq_valid_o (s_req_valid[PORT_1]),
    .mreq_ready_i (s_req_ready[PORT_1]),
    .mreq_op_o    (s_req_op[PORT_1]),
    .mreq_addr_o  (s_req_addr[PORT_1]),
    .mreq_wdata_o (s_req_wdata[PORT_1]),
    .mrsp_valid_i (s_rsp_valid[PORT_1]),
    .mrsp_ready_o (s_rsp_ready[PORT_1]),
    .mrsp_op_i    (s_rsp_op[PORT_1]),
    .mrsp_rdata_i (s_rsp_rdata[PORT_1]),
    .isolate_i    (isolate_1_i),
    .isolated_o   (isolated_1_o)
  );

  //////////////////////////////////////////////////////////////////////
  // shared path
  //////////////////////////////////////////////////////////////////////

  rr_bus_arbiter i_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .s_req_valid_i (s_req_valid),
    .s_req_ready_o (s_req_ready),
    .s_req_op_i    (s_req_op),
    .s_req_addr_i  (s_req_addr),
    .s_req_wdata_i (s_req_wdata),
    .s_rsp_valid_o (s_rsp_valid),
    .s_rsp_ready_i (s_rsp_ready),
    .s_rsp_op_o    (s_rsp_op),
    .s_rsp_rdata_o (s_rsp_rdata),
    .m_req_valid_o (m_req_valid),
    .m_req_ready_i (m_req_ready),
    .m_req_op_o    (m_req_op),
    .m_req_addr_o  (m_req_addr),
    .m_req_wdata_o (m_req_wdata),
    .m_rsp_valid_i (m_rsp_valid),
    .m_rsp_ready_o (m_rsp_ready),
    .m_rsp_op_i    (m_rsp_op),
    .m_rsp_rdata_i (m_rsp_rdata)
  );

  bus_sram i_sram (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (m_req_valid),
    .req_ready_o (m_req_ready),
    .req_op_i    (m_req_op),
    .req_addr_i  (m_req_addr),
    .req_wdata_i (m_req_wdata),
    .rsp_valid_o (m_rsp_valid),
    .rsp_ready_i (m_rsp_ready),
    .rsp_op_o    (m_rsp_op),
    .rsp_rdata_o (m_rsp_rdata)
  );

endmodule

// File: sim/tb_clock.sv
/*
 * testbench clock source, 100 ns period
 */
module tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk_o = 1'b0;  // first rising edge at 50 ns
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

// File: sim/isolated_mem_sva.sv
/*
 * concurrent checks on one bus isolation block
 * pending limit, silence while isolated, request valid stability
 */
module isolated_mem_sva #(
  parameter int unsigned NUM_PENDING = 2
) (
  input logic                                 clk_i,
  input logic                                 rst_i,
  input logic [$clog2(NUM_PENDING + 1)-1:0]   pending_i,
  input logic                                 isolated_i,
  input logic                                 mreq_valid_i,
  input logic                                 mreq_ready_i,
  input logic                                 rsp_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CNT_W = $clog2(NUM_PENDING + 1);

  // counter stays within its limit
  pending_limit : assert property (@(posedge clk_i) disable iff (rst_i)
    pending_i <= CNT_W'(NUM_PENDING))
    else $error("open transaction count above limit");

  isolated_silent : assert property (@(posedge clk_i) disable iff (rst_i)
    isolated_i |-> (!mreq_valid_i && !rsp_valid_i))
    else $error("valid seen while port isolated");

  // offer held until taken
  mreq_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    (mreq_valid_i && !mreq_ready_i) |=> mreq_valid_i)
    else $error("downstream request valid dropped before acceptance");

endmodule

bind bus_isolate isolated_mem_sva #(.NUM_PENDING(NUM_PENDING)) sva_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .pending_i    (pending_q),
  .isolated_i   (isolated_o),
  .mreq_valid_i (mreq_valid_o),
  .mreq_ready_i (mreq_ready_i),
  .rsp_valid_i  (rsp_valid_o)
);

// File: sim/isolated_mem_tb.sv
/*
 * directed tests of the isolated scratch memory
 * reference memory model, lfsr stimulus, per-port handshake tasks
 */
`include "mem_bus_consts.svh"

module isolated_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_bus_pkg::*;

  localparam int  WAIT_MAX = 200;   // cycles before a wait gives up
  localparam time SETTLE   = 10ns;  // sample point after the falling edge

  logic     clk, rst;
  logic     req_valid [2];
  mb_op_e   req_op    [2];
  mb_addr_t req_addr  [2];
  mb_data_t req_wdata [2];
  logic     rsp_ready [2];
  logic     isolate   [2];
  logic     req_ready [2];
  logic     rsp_valid [2];
  mb_op_e   rsp_op    [2];
  mb_data_t rsp_rdata [2];
  logic     isolated  [2];

  mb_data_t ref_mem [2**`MB_ADDR_W];  // reference model
  mb_addr_t written [$];    // addresses holding known data
  logic [31:0] lfsr_q = 32'd98195;
  int          err_cnt = 0;

  tb_clock clock_i (.clk_o(clk));

  isolated_mem_top isolated_mem_top_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .req_valid_0_i (req_valid[0]),
    .req_ready_0_o (req_ready[0]),
    .req_op_0_i    (req_op[0]),
    .req_addr_0_i  (req_addr[0]),
    .req_wdata_0_i (req_wdata[0]),
    .rsp_valid_0_o (rsp_valid[0]),
    .rsp_ready_0_i (rsp_ready[0]),
    .rsp_op_0_o    (rsp_op[0]),
    .rsp_rdata_0_o (rsp_rdata[0]),
    .isolate_0_i   (isolate[0]),
    .isolated_0_o  (isolated[0]),
    .req_valid_1_i (req_valid[1]),
    .req_ready_1_o (req_ready[1]),
    .req_op_1_i    (req_op[1]),
    .req_addr_1_i  (req_addr[1]),
    .req_wdata_1_i (req_wdata[1]),
    .rsp_valid_1_o (rsp_valid[1]),
    .rsp_ready_1_i (rsp_ready[1]),
    .rsp_op_1_o    (rsp_op[1]),
    .rsp_rdata_1_o (rsp_rdata[1]),
    .isolate_1_i   (isolate[1]),
    .isolated_1_o  (isolated[1])
  );

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic mb_data_t rand_bits(input int n);
    mb_data_t r;
    logic     fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input mb_data_t got, input mb_data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_op(input string name, input mb_op_e got, input mb_op_e exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    err_cnt++;
    report_and_finish();
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus handshakes
  //////////////////////////////////////////////////////////////////////

  task automatic send_req(input int p, input mb_op_e op, input mb_addr_t a, input mb_data_t d);
    int n;
    n = 0;
    @(negedge clk);
    req_valid[p] = 1'b1;
    req_op[p]    = op;
    req_addr[p]  = a;
    req_wdata[p] = d;
    #SETTLE;
    while (!req_ready[p]) begin
      if (n == WAIT_MAX) give_up($sformatf("request acceptance on port %0d", p));
      n++;
      @(negedge clk);
      #SETTLE;
    end
    @(posedge clk);  // transfer edge
    @(negedge clk);
    req_valid[p] = 1'b0;
    req_wdata[p] = '0;
  endtask

  task automatic get_rsp(input int p, input mb_op_e exp_op, input mb_data_t exp_data);
    int n;
    n = 0;
    @(negedge clk);
    rsp_ready[p] = 1'b1;
    #SETTLE;
    while (!rsp_valid[p]) begin
      if (n == WAIT_MAX) give_up($sformatf("a response on port %0d", p));
      n++;
      @(negedge clk);
      #SETTLE;
    end
    check_op($sformatf("rsp_op_%0d_o", p), rsp_op[p], exp_op);
    check_data($sformatf("rsp_rdata_%0d_o", p), rsp_rdata[p], exp_data);
    @(posedge clk);
    @(negedge clk);
    rsp_ready[p] = 1'b0;
  endtask

  // offer a request that must be refused while valid stays up
  task automatic offer_stall(input int p, input mb_op_e op, input mb_addr_t a,
                             input mb_data_t d, input int cycles);
    @(negedge clk);
    req_valid[p] = 1'b1;
    req_op[p]    = op;
    req_addr[p]  = a;
    req_wdata[p] = d;
    repeat (cycles) begin
      #SETTLE;
      check_flag($sformatf("req_ready_%0d_o", p), req_ready[p], 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic wait_isolated(input int p, input logic val);
    int n;
    n = 0;
    @(negedge clk);
    #SETTLE;
    while (isolated[p] !== val) begin
      if (n == WAIT_MAX) give_up($sformatf("isolated_%0d_o to become %0b", p, val));
      n++;
      @(negedge clk);
      #SETTLE;
    end
  endtask

  task automatic write_word(input int p, input mb_addr_t a, input mb_data_t d);
    ref_mem[a] = d;
    written.push_back(a);
    send_req(p, OP_WRITE, a, d);
    get_rsp(p, OP_WRITE, '0);  // write ack carries zero data
  endtask

  task automatic read_word(input int p, input mb_addr_t a);
    send_req(p, OP_READ, a, '0);
    get_rsp(p, OP_READ, ref_mem[a]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    #SETTLE;
    check_flag("isolated_0_o", isolated[0], 1'b1);
    check_flag("isolated_1_o", isolated[1], 1'b1);
    check_flag("rsp_valid_0_o", rsp_valid[0], 1'b0);
    check_flag("rsp_valid_1_o", rsp_valid[1], 1'b0);
  endtask

  task automatic test_cross_port();
    @(negedge clk);
    isolate[0] = 1'b0;
    isolate[1] = 1'b0;
    wait_isolated(0, 1'b0);
    wait_isolated(1, 1'b0);
    repeat (6) write_word(0, mb_addr_t'(rand_bits(8)), rand_bits(32));
    repeat (6) read_word(1, written[rand_bits(8) % written.size()]);
  endtask

  task automatic test_interleaved();
    mb_op_e   op   [2][8];
    mb_addr_t addr [2][8];
    mb_data_t data [2][8];
    // port 0 in the low half and port 1 in the high half, each write read back
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 8; i++) begin
        op[p][i]   = (i % 2 == 0) ? OP_WRITE : OP_READ;
        addr[p][i] = (i % 2 == 0) ? {p[0], 7'(rand_bits(7))} : addr[p][i-1];
        data[p][i] = rand_bits(32);
      end
    end
    fork
      for (int i = 0; i < 8; i++) begin
        if (op[0][i] == OP_WRITE) write_word(0, addr[0][i], data[0][i]);
        else read_word(0, addr[0][i]);
      end
      for (int i = 0; i < 8; i++) begin
        if (op[1][i] == OP_WRITE) write_word(1, addr[1][i], data[1][i]);
        else read_word(1, addr[1][i]);
      end
    join
  endtask

  task automatic test_isolate_idle();
    mb_addr_t a;
    mb_data_t d;
    a = mb_addr_t'(rand_bits(8));
    d = rand_bits(32);
    @(negedge clk);
    isolate[1] = 1'b1;
    wait_isolated(1, 1'b1);
    fork
      offer_stall(1, OP_WRITE, a, d, 20);
      begin
        write_word(0, 8'h11, rand_bits(32));  // other port keeps going
        read_word(0, 8'h11);
      end
    join
    @(negedge clk);
    isolate[1] = 1'b0;
    ref_mem[a] = d;
    written.push_back(a);
    send_req(1, OP_WRITE, a, d);
    get_rsp(1, OP_WRITE, '0);
    read_word(1, a);
  endtask

  task automatic test_drain();
    mb_addr_t a0;
    mb_addr_t a1;
    a0 = written[0];
    a1 = written[1];
    send_req(0, OP_READ, a0, '0);  // responses held with rsp_ready low
    send_req(0, OP_READ, a1, '0);
    @(negedge clk);
    isolate[0] = 1'b1;
    repeat (8) begin
      @(negedge clk);
      #SETTLE;
      check_flag("isolated_0_o", isolated[0], 1'b0);
    end
    get_rsp(0, OP_READ, ref_mem[a0]);
    get_rsp(0, OP_READ, ref_mem[a1]);
    check_flag("isolated_0_o", isolated[0], 1'b0);
    wait_isolated(0, 1'b1);
    @(negedge clk);
    isolate[0] = 1'b0;
    wait_isolated(0, 1'b0);
  endtask

  task automatic test_pending_limit();
    mb_addr_t a;
    mb_addr_t b;
    mb_data_t d;
    a = {1'b0, 7'(rand_bits(7))};
    b = written[2];
    d = rand_bits(32);
    ref_mem[a] = d;
    send_req(0, OP_WRITE, a, d);
    send_req(0, OP_READ, a, '0);
    offer_stall(0, OP_READ, b, '0, 20);  // two open, the third refused
    // first response leaves while the count still sits at the limit
    rsp_ready[0] = 1'b1;
    #SETTLE;
    check_flag("rsp_valid_0_o", rsp_valid[0], 1'b1);
    check_flag("req_ready_0_o", req_ready[0], 1'b0);
    check_op("rsp_op_0_o", rsp_op[0], OP_WRITE);
    check_data("rsp_rdata_0_o", rsp_rdata[0], '0);
    @(posedge clk);
    @(negedge clk);
    rsp_ready[0] = 1'b0;
    fork
      send_req(0, OP_READ, b, '0);
      begin
        get_rsp(0, OP_READ, d);
        get_rsp(0, OP_READ, ref_mem[b]);
      end
    join
  endtask

  initial begin
    rst = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req_op[p]    = OP_READ;
      req_addr[p]  = '0;
      req_wdata[p] = '0;
      rsp_ready[p] = 1'b0;
      isolate[p]   = 1'b1;  // ports stay cut out of reset
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_cross_port();
    test_interleaved();
    test_isolate_idle();
    test_drain();
    test_pending_limit();
    report_and_finish();
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/bus_isolate.sv
hdl/rr_bus_arbiter.sv
hdl/bus_sram.sv
hdl/isolated_mem_top.sv
sim/tb_clock.sv
sim/isolated_mem_sva.sv
sim/isolated_mem_tb.sv

// File: Makefile
# Verilator build of the isolated scratch memory testbench

VERILATOR ?= verilator
TOP       ?= isolated_mem_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= All checks passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
